// ==== design/lsu_pkg.sv ====
// memory stage types: access widths, pipeline records, AXI4 channel payloads
package lsu_pkg;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    // coded as funct3 of the load/store instruction
    typedef enum logic [2:0] {
        width_b  = 3'b000,
        width_h  = 3'b001,
        width_w  = 3'b010,
        width_bu = 3'b100,
        width_hu = 3'b101
    } mem_width_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_wen;
        logic        mem_ren;
        logic        mem_wen;
        mem_width_e  width;
        logic [31:0] addr;        // execute result
        logic [31:0] store_data;  // rs2 value
    } ex_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        reg_wen;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;  // same fields on the read side

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

// ==== design/stage_reg.sv ====
// one-entry valid/ready pipeline register with a type-parameter payload
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic load;

    // accept when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= in_data;
        end
    end

    // stalled output must not change under the next stage
    a_hold_stable: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("stage_reg payload changed while stalled");

endmodule

// ==== design/lsu_core.sv ====
// load/store unit: request FSM, AXI master handshakes, store lane alignment, load extension
`timescale 1ns/1ps

module lsu_core import lsu_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    req_valid,
    output logic    req_ready,
    input  ex_req_t req,
    output logic    wb_valid,
    input  logic    wb_ready,
    output wb_t     wb,
    output logic    aw_valid,
    input  logic    aw_ready,
    output axi_aw_t aw,
    output logic    w_valid,
    input  logic    w_ready,
    output axi_w_t  w,
    input  logic    b_valid,
    output logic    b_ready,
    input  axi_b_t  b,
    output logic    ar_valid,
    input  logic    ar_ready,
    output axi_ar_t ar,
    input  logic    r_valid,
    output logic    r_ready,
    input  axi_r_t  r
);

    typedef enum logic [1:0] {
        st_idle,
        st_store,
        st_load,
        st_hold
    } state_e;

    state_e      state;
    ex_req_t     req_q;
    logic [31:0] result_q;
    logic [1:0]  offset;
    logic [4:0]  lane_shift;
    logic [31:0] r_shifted;
    logic [31:0] load_data;
    logic [3:0]  store_strb;
    logic        req_fire;
    logic        r_fire;
    logic        req_aligned;

    assign req_ready  = (state == st_idle);
    assign wb_valid   = (state == st_hold);
    assign req_fire   = req_valid && req_ready;
    assign r_fire     = r_valid && r_ready;
    assign offset     = req_q.addr[1:0];
    assign lane_shift = {offset, 3'b000};  // byte offset in bits

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= st_idle;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_fire) begin
                        if (req.mem_wen) begin
                            state    <= st_store;
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            b_ready  <= 1'b1;
                        end else if (req.mem_ren) begin
                            state    <= st_load;
                            ar_valid <= 1'b1;
                            r_ready  <= 1'b1;
                        end else begin
                            state <= st_hold;  // pass-through
                        end
                    end
                end
                st_store: begin
                    if (aw_valid && aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_valid && w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (b_valid && b_ready) begin
                        b_ready <= 1'b0;
                        state   <= st_hold;
                    end
                end
                st_load: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (r_fire) begin
                        r_ready <= 1'b0;
                        state   <= st_hold;
                    end
                end
                st_hold: begin
                    if (wb_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // stores and plain ops report the execute result
    always_ff @(posedge clock) begin
        if (req_fire) begin
            req_q    <= req;
            result_q <= req.addr;
        end else if (r_fire) begin
            result_q <= load_data;
        end
    end

    assign r_shifted = r.data >> lane_shift;

    always_comb begin
        case (req_q.width)
            width_b:  load_data = {{24{r_shifted[7]}}, r_shifted[7:0]};
            width_h:  load_data = {{16{r_shifted[15]}}, r_shifted[15:0]};
            width_w:  load_data = r.data;
            width_bu: load_data = {24'h0, r_shifted[7:0]};
            width_hu: load_data = {16'h0, r_shifted[15:0]};
            default:  load_data = 32'h0;
        endcase
    end

    always_comb begin
        case (req_q.width)
            width_b: store_strb = 4'b0001 << offset;
            width_h: store_strb = 4'b0011 << offset;
            width_w: store_strb = 4'b1111;
            default: store_strb = 4'b0000;
        endcase
    end

    assign aw.addr  = {req_q.addr[31:2], 2'b00};
    assign aw.id    = 4'd0;
    assign aw.len   = 8'd0;    // single beat
    assign aw.size  = 3'b010;  // four bytes
    assign aw.burst = 2'b01;
    assign ar       = aw;      // reads use the same word address

    assign w.data = req_q.store_data << lane_shift;
    assign w.strb = store_strb;
    assign w.last = 1'b1;

    assign wb.pc      = req_q.pc;
    assign wb.rd      = req_q.rd;
    assign wb.reg_wen = req_q.reg_wen;
    assign wb.data    = result_q;

    assign req_aligned = (req.width == width_w) ? (req.addr[1:0] == 2'b00) :
                         (req.width == width_h || req.width == width_hu) ? !req.addr[0] :
                         1'b1;

    a_aligned: assert property (@(posedge clock) disable iff (reset)
        req_fire && (req.mem_ren || req.mem_wen) |-> req_aligned)
        else $error("misaligned access at %h", req.addr);

    a_rw_exclusive: assert property (@(posedge clock) disable iff (reset)
        req_valid |-> !(req.mem_ren && req.mem_wen))
        else $error("request sets both read and write");

    a_b_okay: assert property (@(posedge clock) disable iff (reset)
        b_valid && b_ready |-> b.resp == AXI_RESP_OKAY && b.id == aw.id)
        else $error("write response not OKAY");

    a_r_okay: assert property (@(posedge clock) disable iff (reset)
        r_fire |-> r.resp == AXI_RESP_OKAY && r.last && r.id == ar.id)
        else $error("read response not OKAY");

endmodule

// ==== design/axi_sram.sv ====
// single-beat AXI4 slave over a word array with byte strobes and a response delay
`timescale 1ns/1ps

module axi_sram import lsu_pkg::*; #(
    parameter int mem_words  = 256,
    parameter int resp_delay = 2
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_aw_t aw,
    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,
    output logic    b_valid,
    input  logic    b_ready,
    output axi_b_t  b,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_ar_t ar,
    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r
);

    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
    localparam int cnt_w = $clog2(resp_delay) + 1;

    typedef enum logic [2:0] {
        st_clear,
        st_idle,
        st_wdata,
        st_wait,
        st_resp
    } state_e;

    logic [31:0]      mem [mem_words];
    state_e           state;
    logic [idx_w-1:0] clr_idx;
    logic [idx_w-1:0] word_idx;
    logic [cnt_w-1:0] delay_cnt;
    logic [3:0]       id_q;
    logic [31:0]      rdata_q;
    logic             is_write;
    logic             aw_fire;
    logic             w_fire;
    logic             ar_fire;
    logic             resp_fire;

    assign aw_ready = (state == st_idle);
    assign ar_ready = (state == st_idle) && !aw_valid;  // writes win a tie
    assign w_ready  = (state == st_wdata);
    assign b_valid  = (state == st_resp) && is_write;
    assign r_valid  = (state == st_resp) && !is_write;

    assign aw_fire   = aw_valid && aw_ready;
    assign w_fire    = w_valid && w_ready;
    assign ar_fire   = ar_valid && ar_ready;
    assign resp_fire = (b_valid && b_ready) || (r_valid && r_ready);

    // the array is swept to zero, one word per cycle, before the first request
    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= st_clear;
            clr_idx <= '0;
        end else begin
            case (state)
                st_clear: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == idx_w'(mem_words - 1)) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (aw_fire) begin
                        state <= st_wdata;
                    end else if (ar_fire) begin
                        state <= st_wait;
                    end
                end
                st_wdata: begin
                    if (w_fire) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (delay_cnt == '0) begin
                        state <= st_resp;
                    end
                end
                st_resp: begin
                    if (resp_fire) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_fire || ar_fire) begin
            word_idx <= aw_fire ? aw.addr[idx_w+1:2] : ar.addr[idx_w+1:2];
            id_q     <= aw_fire ? aw.id : ar.id;  // echoed on b or r
            is_write <= aw_fire;
        end
        if (ar_fire || w_fire) begin
            delay_cnt <= cnt_w'(resp_delay - 1);
        end else if (state == st_wait) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
        if (state == st_wait && delay_cnt == '0 && !is_write) begin
            rdata_q <= mem[word_idx];
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_clear) begin
            mem[clr_idx] <= '0;
        end else if (w_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i]) begin
                    mem[word_idx][8*i +: 8] <= w.data[8*i +: 8];  // lane by lane
                end
            end
        end
    end

    assign b.resp = AXI_RESP_OKAY;
    assign b.id   = id_q;
    assign r.data = rdata_q;
    assign r.resp = AXI_RESP_OKAY;
    assign r.last = 1'b1;
    assign r.id   = id_q;

    a_aw_range: assert property (@(posedge clock) disable iff (reset)
        aw_fire |-> aw.addr[31:2] < mem_words && aw.len == 8'd0)
        else $error("write address %h outside memory", aw.addr);

    a_ar_range: assert property (@(posedge clock) disable iff (reset)
        ar_fire |-> ar.addr[31:2] < mem_words && ar.len == 8'd0)
        else $error("read address %h outside memory", ar.addr);

endmodule

// ==== design/lsu_top.sv ====
// memory stage top: input register, load/store unit, AXI SRAM, write-back register
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
    parameter int mem_words  = 256,
    parameter int resp_delay = 2
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    output logic    in_ready,
    input  ex_req_t in_req,
    output logic    out_valid,
    input  logic    out_ready,
    output wb_t     out_wb
);

    logic    req_valid;
    logic    req_ready;
    ex_req_t req;
    logic    wb_valid;
    logic    wb_ready;
    wb_t     wb;
    logic    aw_valid;
    logic    aw_ready;
    axi_aw_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    b_valid;
    logic    b_ready;
    axi_b_t  b;
    logic    ar_valid;
    logic    ar_ready;
    axi_ar_t ar;
    logic    r_valid;
    logic    r_ready;
    axi_r_t  r;

    stage_reg #(
        .payload_t(ex_req_t)
    ) ex_latch (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_data  (in_req),
        .out_valid(req_valid),
        .out_ready(req_ready),
        .out_data (req)
    );

    lsu_core core (
        .clock    (clock),
        .reset    (reset),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .wb_valid (wb_valid),
        .wb_ready (wb_ready),
        .wb       (wb),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    axi_sram #(
        .mem_words (mem_words),
        .resp_delay(resp_delay)
    ) sram (
        .clock   (clock),
        .reset   (reset),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .aw      (aw),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .w       (w),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .b       (b),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .ar      (ar),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r       (r)
    );

    stage_reg #(
        .payload_t(wb_t)
    ) wb_latch (
        .clock    (clock),
        .reset    (reset),
        .in_valid (wb_valid),
        .in_ready (wb_ready),
        .in_data  (wb),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data (out_wb)
    );

endmodule

// ==== tb/lsu_tb.sv ====
// testbench for lsu_top with clock, reset, golden-file requests, LFSR back-pressure and write-back checks
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

    localparam int max_records = 64;
    localparam int fields      = 12;   // words per golden line
    localparam int wait_limit  = 2000; // covers the SRAM clear after reset

    logic    clock;
    logic    reset;
    logic    in_valid;
    logic    in_ready;
    ex_req_t in_req;
    logic    out_valid;
    logic    out_ready;
    wb_t     out_wb;

    logic [31:0] golden [max_records*fields];
    logic [31:0] lfsr_state;
    int          n_records;

    lsu_top UUT (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_req   (in_req),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_wb   (out_wb)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic take_random_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic ex_req_t golden_req(input int idx);
        ex_req_t req;
        int      base;
        base           = idx * fields;
        req.pc         = golden[base];
        req.rd         = golden[base+1][4:0];
        req.reg_wen    = golden[base+2][0];
        req.mem_ren    = golden[base+3][0];
        req.mem_wen    = golden[base+4][0];
        req.width      = mem_width_e'(golden[base+5][2:0]);
        req.addr       = golden[base+6];
        req.store_data = golden[base+7];
        return req;
    endfunction

    function automatic wb_t golden_wb(input int idx);
        wb_t exp_wb;
        int  base;
        base           = idx * fields;
        exp_wb.pc      = golden[base+8];
        exp_wb.rd      = golden[base+9][4:0];
        exp_wb.reg_wen = golden[base+10][0];
        exp_wb.data    = golden[base+11];
        return exp_wb;
    endfunction

    task automatic check_bit(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            fail_now($sformatf("Fail at %0t ns: %s is %b, expected %b",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_wb(input wb_t actual, input wb_t expected, input int idx);
        if (actual.pc !== expected.pc) begin
            fail_now($sformatf("Fail at %0t ns: record %0d pc is %h, expected %h",
                               $time, idx, actual.pc, expected.pc));
        end
        if (actual.rd !== expected.rd) begin
            fail_now($sformatf("Fail at %0t ns: record %0d rd is %h, expected %h",
                               $time, idx, actual.rd, expected.rd));
        end
        if (actual.reg_wen !== expected.reg_wen) begin
            fail_now($sformatf("Fail at %0t ns: record %0d reg_wen is %b, expected %b",
                               $time, idx, actual.reg_wen, expected.reg_wen));
        end
        if (actual.data !== expected.data) begin
            fail_now($sformatf("Fail at %0t ns: record %0d data is %h, expected %h",
                               $time, idx, actual.data, expected.data));
        end
    endtask

    // called just after a rising edge; returns just after the transfer edge
    task automatic send_req(input int idx);
        int cycles;
        cycles   = 0;
        in_valid = 1'b1;
        in_req   = golden_req(idx);
        @(negedge clock);
        while (!in_ready) begin
            cycles++;
            if (cycles > wait_limit) begin
                fail_now($sformatf("in_ready stayed low too long for request %0d", idx));
            end
            @(negedge clock);
        end
        @(posedge clock);
        #1;
    endtask

    task automatic collect_wb(input int idx);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clock);
            #1 out_ready = take_random_bit();
            @(negedge clock);  // inputs settled before the deciding edge
            if (out_valid && out_ready) begin
                check_wb(out_wb, golden_wb(idx), idx);
                done = 1'b1;
            end else begin
                cycles++;
                if (cycles > wait_limit) begin
                    fail_now($sformatf("no write-back record %0d arrived on out_valid", idx));
                end
            end
        end
    endtask

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b0;
        lfsr_state = 32'hb11;
        n_records  = 0;
        $readmemh("tb/lsu_golden.txt", golden);
        while (n_records < max_records && !$isunknown(golden[n_records*fields])) begin
            n_records++;
        end
        if (n_records == 0) begin
            fail_now("the golden file holds no records");
        end
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        check_bit(out_valid, 1'b0, "out_valid after reset");
        check_bit(in_ready, 1'b1, "in_ready after reset");
        @(posedge clock);
        #1;
        fork
            begin
                for (int i = 0; i < n_records; i++) begin
                    send_req(i);
                end
                in_valid = 1'b0;
            end
            begin
                for (int j = 0; j < n_records; j++) begin
                    collect_wb(j);
                end
            end
        join
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
design/lsu_pkg.sv
design/stage_reg.sv
design/lsu_core.sv
design/axi_sram.sv
design/lsu_top.sv
tb/lsu_tb.sv

// ==== tb/lsu_golden.txt ====
// request: pc rd reg_wen mem_ren mem_wen width addr store_data
// expected: pc rd reg_wen data  (width 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu)
00001000 01 1 0 0 0 12345678 00000000  00001000 01 1 12345678
00001004 00 0 0 1 2 00000100 a1b2c3d4  00001004 00 0 00000100
00001008 02 1 1 0 2 00000100 00000000  00001008 02 1 a1b2c3d4
0000100c 00 0 0 1 0 00000104 ffffff11  0000100c 00 0 00000104
00001010 00 0 0 1 0 00000105 abcdef22  00001010 00 0 00000105
00001014 00 0 0 1 0 00000106 12345633  00001014 00 0 00000106
00001018 00 0 0 1 0 00000107 00000044  00001018 00 0 00000107
0000101c 03 1 1 0 2 00000104 00000000  0000101c 03 1 44332211
00001020 00 0 0 1 1 00000108 dead8765  00001020 00 0 00000108
00001024 00 0 0 1 1 0000010a 0000f00d  00001024 00 0 0000010a
00001028 04 1 1 0 2 00000108 00000000  00001028 04 1 f00d8765
0000102c 00 0 0 1 0 00000101 0000005a  0000102c 00 0 00000101
00001030 05 1 1 0 2 00000100 00000000  00001030 05 1 a1b25ad4
00001034 06 1 1 0 0 00000108 00000000  00001034 06 1 00000065
00001038 07 1 1 0 0 00000109 00000000  00001038 07 1 ffffff87
0000103c 08 1 1 0 0 0000010a 00000000  0000103c 08 1 0000000d
00001040 09 1 1 0 0 0000010b 00000000  00001040 09 1 fffffff0
00001044 0a 1 1 0 0 00000100 00000000  00001044 0a 1 ffffffd4
00001048 0b 1 1 0 4 00000109 00000000  00001048 0b 1 00000087
0000104c 0c 1 1 0 4 0000010b 00000000  0000104c 0c 1 000000f0
00001050 0d 1 1 0 4 00000100 00000000  00001050 0d 1 000000d4
00001054 0e 1 1 0 4 00000106 00000000  00001054 0e 1 00000033
00001058 0f 1 1 0 1 00000108 00000000  00001058 0f 1 ffff8765
0000105c 10 1 1 0 1 0000010a 00000000  0000105c 10 1 fffff00d
00001060 11 1 1 0 1 00000104 00000000  00001060 11 1 00002211
00001064 12 1 1 0 1 00000106 00000000  00001064 12 1 00004433
00001068 13 1 1 0 5 00000108 00000000  00001068 13 1 00008765
0000106c 14 1 1 0 5 0000010a 00000000  0000106c 14 1 0000f00d
00001070 15 1 1 0 5 00000100 00000000  00001070 15 1 00005ad4
00001074 16 1 1 0 5 00000102 00000000  00001074 16 1 0000a1b2
00001078 17 1 1 0 2 000001fc 00000000  00001078 17 1 00000000
0000107c 00 0 0 0 0 cafef00d 00000000  0000107c 00 0 cafef00d
